/* src/cpu_isa_pkg.sv */
// RV32I subset ISA definitions
// Field widths, opcode and ALU encodings, instruction layout
`default_nettype none

package cpu_isa_pkg;

   localparam int xlen       = 32;   // Data and address width
   localparam int reg_addr_w = 5;    // 32 architectural registers

   // Major opcodes of the kept instructions
   typedef enum logic [6:0] {
      op_r      = 7'b0110011,
      op_imm    = 7'b0010011,
      op_load   = 7'b0000011,
      op_store  = 7'b0100011,
      op_branch = 7'b1100011
   } opcode_e;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_slt
   } alu_op_e;

   // ==================================================
   // funct3 encodings
   // ==================================================
   localparam logic [2:0] f3_add_sub = 3'b000;   // ADD, SUB, ADDI
   localparam logic [2:0] f3_slt     = 3'b010;
   localparam logic [2:0] f3_xor     = 3'b100;
   localparam logic [2:0] f3_or      = 3'b110;
   localparam logic [2:0] f3_and     = 3'b111;
   localparam logic [2:0] f3_lw      = 3'b010;
   localparam logic [2:0] f3_sw      = 3'b010;
   localparam logic [2:0] f3_beq     = 3'b000;

   // R-type layout; immediates are rebuilt from these fields
   typedef struct packed {
      logic [6:0]            funct7;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      opcode_e               opc;
   } instr_t;

   localparam instr_t nop_instr = 32'h0000_0013;   // ADDI x0, x0, 0

endpackage : cpu_isa_pkg

`default_nettype wire

/* src/cpu_pipe_pkg.sv */
// Pipeline types
// Stage register layouts, forwarding and result select codes
`default_nettype none

package cpu_pipe_pkg;

   // Operand source in execute
   typedef enum logic [1:0] {
      fwd_none = 2'b00,   // Register file value from decode
      fwd_wb   = 2'b01,   // Write-back result
      fwd_mem  = 2'b10    // Memory-stage ALU result
   } fwd_sel_e;

   typedef enum logic {
      res_alu = 1'b0,
      res_mem = 1'b1
   } result_src_e;

   // ==================================================
   // Stage registers
   // ==================================================
   typedef struct packed {
      logic                  reg_wr_en;
      logic                  mem_wr_en;
      logic                  branch;       // BEQ
      logic                  alu_src_imm;  // B operand from immediate
      cpu_isa_pkg::alu_op_e  alu_op;
      result_src_e           result_src;
   } ex_ctrl_t;

   typedef struct packed {
      ex_ctrl_t                           ctrl;
      logic [cpu_isa_pkg::xlen-1:0]       pc;
      logic [cpu_isa_pkg::xlen-1:0]       op_a;   // rs1 value
      logic [cpu_isa_pkg::xlen-1:0]       op_b;   // rs2 value
      logic [cpu_isa_pkg::xlen-1:0]       imm;
      logic [cpu_isa_pkg::reg_addr_w-1:0] rs1;
      logic [cpu_isa_pkg::reg_addr_w-1:0] rs2;
      logic [cpu_isa_pkg::reg_addr_w-1:0] rd;
   } id_ex_t;

   typedef struct packed {
      logic                               reg_wr_en;
      logic                               mem_wr_en;
      result_src_e                        result_src;
      logic [cpu_isa_pkg::xlen-1:0]       alu_result;   // Also the data address
      logic [cpu_isa_pkg::xlen-1:0]       store_data;
      logic [cpu_isa_pkg::reg_addr_w-1:0] rd;
   } ex_mem_t;

   typedef struct packed {
      logic                               reg_wr_en;
      result_src_e                        result_src;
      logic [cpu_isa_pkg::xlen-1:0]       alu_result;
      logic [cpu_isa_pkg::xlen-1:0]       load_data;
      logic [cpu_isa_pkg::reg_addr_w-1:0] rd;
   } mem_wb_t;

   // Final register write, shared by regfile and forwarding
   typedef struct packed {
      logic                               en;
      logic [cpu_isa_pkg::reg_addr_w-1:0] rd;
      logic [cpu_isa_pkg::xlen-1:0]       data;
   } wb_write_t;

endpackage : cpu_pipe_pkg

`default_nettype wire

/* src/cpu_fetch.sv */
// Fetch stage
// Program counter and the fetch/decode register
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch (
   input  logic                         sys_clk,
   input  logic                         sys_rst_n,
   input  logic                         stall,
   input  logic                         flush,
   input  logic                         branch_taken,
   input  logic [cpu_isa_pkg::xlen-1:0] branch_target,
   input  logic [cpu_isa_pkg::xlen-1:0] pfm_rd_instr,
   output logic [cpu_isa_pkg::xlen-1:0] pfm_req_addr,
   output logic [cpu_isa_pkg::xlen-1:0] if_pc,
   output cpu_isa_pkg::instr_t          if_instr
);

   logic [cpu_isa_pkg::xlen-1:0] pc;
   logic [cpu_isa_pkg::xlen-1:0] pc_next;

   assign pc_next      = branch_taken ? branch_target : pc + 32'd4;
   assign pfm_req_addr = pc;   // Instruction comes back same cycle

   always_ff @(posedge sys_clk or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         pc <= '0;
      end else if (!stall) begin   // Hold on load-use
         pc <= pc_next;
      end
   end

   // Fetch/decode register
   always_ff @(posedge sys_clk or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         if_pc    <= '0;
         if_instr <= cpu_isa_pkg::nop_instr;
      end else if (flush) begin
         if_instr <= cpu_isa_pkg::nop_instr;   // Kill wrong-path instruction
      end else if (!stall) begin
         if_pc    <= pc;
         if_instr <= pfm_rd_instr;
      end
   end

endmodule : cpu_fetch

`default_nettype wire

/* src/cpu_reg_file.sv */
// Integer register file
// 32 x 32, two async reads, one write, x0 tied to zero, write-through
`timescale 1ns/1ps
`default_nettype none

module cpu_reg_file (
   input  logic                               sys_clk,
   input  logic                               sys_rst_n,
   input  logic [cpu_isa_pkg::reg_addr_w-1:0] rs1,
   input  logic [cpu_isa_pkg::reg_addr_w-1:0] rs2,
   input  cpu_pipe_pkg::wb_write_t            wb,
   output logic [cpu_isa_pkg::xlen-1:0]       rd1,
   output logic [cpu_isa_pkg::xlen-1:0]       rd2
);

   logic [cpu_isa_pkg::xlen-1:0] regs [32];

   always_ff @(posedge sys_clk or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         regs <= '{default: '0};
      end else if (wb.en && wb.rd != '0) begin   // x0 never written
         regs[wb.rd] <= wb.data;
      end
   end

   // Same-cycle write is visible to decode
   always_comb begin
      rd1 = (wb.en && wb.rd == rs1) ? wb.data : regs[rs1];
      rd2 = (wb.en && wb.rd == rs2) ? wb.data : regs[rs2];
      if (rs1 == '0) rd1 = '0;
      if (rs2 == '0) rd2 = '0;
   end

endmodule : cpu_reg_file

`default_nettype wire

/* src/cpu_decode.sv */
// Decode stage
// Control decode, immediate build, register read, decode/execute register
`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
   input  logic                               sys_clk,
   input  logic                               sys_rst_n,
   input  logic                               stall,
   input  logic                               flush,
   input  logic [cpu_isa_pkg::xlen-1:0]       if_pc,
   input  cpu_isa_pkg::instr_t                if_instr,
   input  cpu_pipe_pkg::wb_write_t            wb,
   output logic [cpu_isa_pkg::reg_addr_w-1:0] id_rs1,
   output logic [cpu_isa_pkg::reg_addr_w-1:0] id_rs2,
   output cpu_pipe_pkg::id_ex_t               id_ex
);

   cpu_pipe_pkg::ex_ctrl_t       ctrl;
   logic [cpu_isa_pkg::xlen-1:0] imm;
   logic [cpu_isa_pkg::xlen-1:0] rd1;
   logic [cpu_isa_pkg::xlen-1:0] rd2;

   assign id_rs1 = if_instr.rs1;
   assign id_rs2 = if_instr.rs2;

   cpu_reg_file u_reg_file (
      .sys_clk   (sys_clk),
      .sys_rst_n (sys_rst_n),
      .rs1       (if_instr.rs1),
      .rs2       (if_instr.rs2),
      .wb        (wb),
      .rd1       (rd1),
      .rd2       (rd2)
   );

   // ==================================================
   // Control decode
   // ==================================================
   always_comb begin
      ctrl            = '0;   // Unknown encodings become bubbles
      ctrl.alu_op     = cpu_isa_pkg::alu_add;
      ctrl.result_src = cpu_pipe_pkg::res_alu;
      case (if_instr.opc)
         cpu_isa_pkg::op_r: begin
            ctrl.reg_wr_en = 1'b1;
            case (if_instr.funct3)
               cpu_isa_pkg::f3_add_sub:
                  ctrl.alu_op = if_instr.funct7[5] ? cpu_isa_pkg::alu_sub
                                                   : cpu_isa_pkg::alu_add;
               cpu_isa_pkg::f3_slt: ctrl.alu_op = cpu_isa_pkg::alu_slt;
               cpu_isa_pkg::f3_xor: ctrl.alu_op = cpu_isa_pkg::alu_xor;
               cpu_isa_pkg::f3_or:  ctrl.alu_op = cpu_isa_pkg::alu_or;
               cpu_isa_pkg::f3_and: ctrl.alu_op = cpu_isa_pkg::alu_and;
               default:             ctrl.reg_wr_en = 1'b0;
            endcase
         end
         cpu_isa_pkg::op_imm: begin   // ADDI only
            ctrl.reg_wr_en   = (if_instr.funct3 == cpu_isa_pkg::f3_add_sub);
            ctrl.alu_src_imm = 1'b1;
         end
         cpu_isa_pkg::op_load: begin
            ctrl.reg_wr_en   = (if_instr.funct3 == cpu_isa_pkg::f3_lw);
            ctrl.alu_src_imm = 1'b1;
            ctrl.result_src  = cpu_pipe_pkg::res_mem;
         end
         cpu_isa_pkg::op_store: begin
            ctrl.mem_wr_en   = (if_instr.funct3 == cpu_isa_pkg::f3_sw);
            ctrl.alu_src_imm = 1'b1;
         end
         cpu_isa_pkg::op_branch: begin   // BEQ compares by subtraction
            ctrl.branch = (if_instr.funct3 == cpu_isa_pkg::f3_beq);
            ctrl.alu_op = cpu_isa_pkg::alu_sub;
         end
         default: ;
      endcase
   end

   // Sign-extended immediates, rebuilt from R-type fields
   always_comb begin
      case (if_instr.opc)
         cpu_isa_pkg::op_store:
            imm = {{20{if_instr.funct7[6]}}, if_instr.funct7, if_instr.rd};
         cpu_isa_pkg::op_branch:
            imm = {{20{if_instr.funct7[6]}}, if_instr.rd[0], if_instr.funct7[5:0],
                   if_instr.rd[4:1], 1'b0};
         default:   // I-type
            imm = {{20{if_instr.funct7[6]}}, if_instr.funct7, if_instr.rs2};
      endcase
   end

   // Decode/execute register
   always_ff @(posedge sys_clk or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         id_ex <= '0;
      end else begin
         id_ex.ctrl <= (flush || stall) ? '0 : ctrl;   // Bubble or kill
         id_ex.pc   <= if_pc;
         id_ex.op_a <= rd1;
         id_ex.op_b <= rd2;
         id_ex.imm  <= imm;
         id_ex.rs1  <= if_instr.rs1;
         id_ex.rs2  <= if_instr.rs2;
         id_ex.rd   <= if_instr.rd;
      end
   end

endmodule : cpu_decode

`default_nettype wire

/* src/cpu_hazard_unit.sv */
// Hazard unit
// Forwarding select, load-use stall, branch flush
`timescale 1ns/1ps
`default_nettype none

module cpu_hazard_unit (
   input  logic [cpu_isa_pkg::reg_addr_w-1:0] id_rs1,
   input  logic [cpu_isa_pkg::reg_addr_w-1:0] id_rs2,
   input  logic [cpu_isa_pkg::reg_addr_w-1:0] ex_rs1,
   input  logic [cpu_isa_pkg::reg_addr_w-1:0] ex_rs2,
   input  logic [cpu_isa_pkg::reg_addr_w-1:0] ex_rd,
   input  logic                               ex_is_load,
   input  logic [cpu_isa_pkg::reg_addr_w-1:0] mem_rd,
   input  logic                               mem_reg_wr_en,
   input  cpu_pipe_pkg::wb_write_t            wb,
   input  logic                               branch_taken,
   output logic                               stall,
   output logic                               flush_id,
   output logic                               flush_ex,
   output cpu_pipe_pkg::fwd_sel_e             fwd_a,
   output cpu_pipe_pkg::fwd_sel_e             fwd_b
);

   logic load_use;

   // Memory stage first, then write-back; x0 never forwards
   function automatic cpu_pipe_pkg::fwd_sel_e pick_fwd(
      input logic [cpu_isa_pkg::reg_addr_w-1:0] rs
   );
      if (rs == '0) return cpu_pipe_pkg::fwd_none;
      if (mem_reg_wr_en && mem_rd == rs) return cpu_pipe_pkg::fwd_mem;
      if (wb.en && wb.rd == rs) return cpu_pipe_pkg::fwd_wb;
      return cpu_pipe_pkg::fwd_none;
   endfunction

   // Re-evaluated on stage register changes too
   always_comb begin
      fwd_a = pick_fwd(ex_rs1);
      fwd_b = pick_fwd(ex_rs2);
   end

   // Load in execute, consumer in decode
   assign load_use = ex_is_load && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

   assign stall    = load_use && !branch_taken;   // Flush wins
   assign flush_id = branch_taken;
   assign flush_ex = branch_taken;

endmodule : cpu_hazard_unit

`default_nettype wire

/* src/cpu_execute.sv */
// Execute stage
// Operand forwarding, ALU, BEQ resolution, execute/memory register
`timescale 1ns/1ps
`default_nettype none

module cpu_execute (
   input  logic                               sys_clk,
   input  logic                               sys_rst_n,
   input  cpu_pipe_pkg::id_ex_t               id_ex,
   input  cpu_pipe_pkg::fwd_sel_e             fwd_a,
   input  cpu_pipe_pkg::fwd_sel_e             fwd_b,
   input  logic [cpu_isa_pkg::xlen-1:0]       mem_fwd_data,
   input  cpu_pipe_pkg::wb_write_t            wb,
   output logic                               branch_taken,
   output logic [cpu_isa_pkg::xlen-1:0]       branch_target,
   output logic [cpu_isa_pkg::reg_addr_w-1:0] ex_rs1,
   output logic [cpu_isa_pkg::reg_addr_w-1:0] ex_rs2,
   output logic [cpu_isa_pkg::reg_addr_w-1:0] ex_rd,
   output logic                               ex_is_load,
   output cpu_pipe_pkg::ex_mem_t              ex_mem
);

   logic [cpu_isa_pkg::xlen-1:0] src_a;
   logic [cpu_isa_pkg::xlen-1:0] src_b;   // Also the store data
   logic [cpu_isa_pkg::xlen-1:0] alu_b;
   logic [cpu_isa_pkg::xlen-1:0] alu_out;
   logic                         alu_zero;

   assign ex_rs1     = id_ex.rs1;
   assign ex_rs2     = id_ex.rs2;
   assign ex_rd      = id_ex.rd;
   assign ex_is_load = id_ex.ctrl.reg_wr_en && id_ex.ctrl.result_src == cpu_pipe_pkg::res_mem;

   // ==================================================
   // Forwarding muxes
   // ==================================================
   always_comb begin
      case (fwd_a)
         cpu_pipe_pkg::fwd_mem: src_a = mem_fwd_data;
         cpu_pipe_pkg::fwd_wb:  src_a = wb.data;
         default:               src_a = id_ex.op_a;
      endcase
      case (fwd_b)
         cpu_pipe_pkg::fwd_mem: src_b = mem_fwd_data;
         cpu_pipe_pkg::fwd_wb:  src_b = wb.data;
         default:               src_b = id_ex.op_b;
      endcase
   end

   assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : src_b;

   // ALU
   always_comb begin
      case (id_ex.ctrl.alu_op)
         cpu_isa_pkg::alu_sub: alu_out = src_a - alu_b;
         cpu_isa_pkg::alu_and: alu_out = src_a & alu_b;
         cpu_isa_pkg::alu_or:  alu_out = src_a | alu_b;
         cpu_isa_pkg::alu_xor: alu_out = src_a ^ alu_b;
         cpu_isa_pkg::alu_slt: alu_out = {31'd0, $signed(src_a) < $signed(alu_b)};
         default:              alu_out = src_a + alu_b;
      endcase
   end

   assign alu_zero      = (alu_out == '0);
   assign branch_taken  = id_ex.ctrl.branch && alu_zero;   // BEQ only
   assign branch_target = id_ex.pc + id_ex.imm;

   // Execute/memory register
   always_ff @(posedge sys_clk or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         ex_mem <= '0;
      end else begin
         ex_mem.reg_wr_en  <= id_ex.ctrl.reg_wr_en;
         ex_mem.mem_wr_en  <= id_ex.ctrl.mem_wr_en;
         ex_mem.result_src <= id_ex.ctrl.result_src;
         ex_mem.alu_result <= alu_out;
         ex_mem.store_data <= src_b;
         ex_mem.rd         <= id_ex.rd;
      end
   end

endmodule : cpu_execute

`default_nettype wire

/* src/cpu_mem_wb.sv */
// Memory and write-back stages
// Data port drive, memory/write-back register, result select
`timescale 1ns/1ps
`default_nettype none

module cpu_mem_wb (
   input  logic                               sys_clk,
   input  logic                               sys_rst_n,
   input  cpu_pipe_pkg::ex_mem_t              ex_mem,
   input  logic [cpu_isa_pkg::xlen-1:0]       dfm_rd_data,
   output logic [cpu_isa_pkg::xlen-1:0]       dfm_req_addr,
   output logic                               dfm_wr_en,
   output logic [cpu_isa_pkg::xlen-1:0]       dfm_wr_data,
   output logic [cpu_isa_pkg::xlen-1:0]       mem_fwd_data,
   output logic [cpu_isa_pkg::reg_addr_w-1:0] mem_rd,
   output logic                               mem_reg_wr_en,
   output cpu_pipe_pkg::wb_write_t            wb
);

   cpu_pipe_pkg::mem_wb_t mem_wb;

   // Data port, read is combinational
   assign dfm_req_addr = ex_mem.alu_result;
   assign dfm_wr_en    = ex_mem.mem_wr_en;
   assign dfm_wr_data  = ex_mem.store_data;

   // Hazard and forwarding taps
   assign mem_fwd_data  = ex_mem.alu_result;
   assign mem_rd        = ex_mem.rd;
   assign mem_reg_wr_en = ex_mem.reg_wr_en;

   always_ff @(posedge sys_clk or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         mem_wb <= '0;
      end else begin
         mem_wb.reg_wr_en  <= ex_mem.reg_wr_en;
         mem_wb.result_src <= ex_mem.result_src;
         mem_wb.alu_result <= ex_mem.alu_result;
         mem_wb.load_data  <= dfm_rd_data;
         mem_wb.rd         <= ex_mem.rd;
      end
   end

   // Result select
   assign wb.en   = mem_wb.reg_wr_en;
   assign wb.rd   = mem_wb.rd;
   assign wb.data = (mem_wb.result_src == cpu_pipe_pkg::res_mem) ? mem_wb.load_data
                                                                 : mem_wb.alu_result;

endmodule : cpu_mem_wb

`default_nettype wire

/* src/cpu_pipeline.sv */
// Five-stage RV32I subset pipeline, top level
// Fetch, decode, execute, memory/write-back and hazard unit wiring
`timescale 1ns/1ps
`default_nettype none

module cpu_pipeline (
   input  logic                         sys_clk,
   input  logic                         sys_rst_n,
   input  logic [cpu_isa_pkg::xlen-1:0] pfm_rd_instr,
   input  logic [cpu_isa_pkg::xlen-1:0] dfm_rd_data,
   output logic [cpu_isa_pkg::xlen-1:0] pfm_req_addr,
   output logic [cpu_isa_pkg::xlen-1:0] dfm_req_addr,
   output logic                         dfm_wr_en,
   output logic [cpu_isa_pkg::xlen-1:0] dfm_wr_data
);

   // ==================================================
   // Stage interconnect
   // ==================================================
   logic [cpu_isa_pkg::xlen-1:0]       if_pc;
   cpu_isa_pkg::instr_t                if_instr;
   logic [cpu_isa_pkg::reg_addr_w-1:0] id_rs1;
   logic [cpu_isa_pkg::reg_addr_w-1:0] id_rs2;
   cpu_pipe_pkg::id_ex_t               id_ex;
   cpu_pipe_pkg::ex_mem_t              ex_mem;
   cpu_pipe_pkg::wb_write_t            wb;
   logic                               branch_taken;
   logic [cpu_isa_pkg::xlen-1:0]       branch_target;
   logic [cpu_isa_pkg::reg_addr_w-1:0] ex_rs1;
   logic [cpu_isa_pkg::reg_addr_w-1:0] ex_rs2;
   logic [cpu_isa_pkg::reg_addr_w-1:0] ex_rd;
   logic                               ex_is_load;
   logic [cpu_isa_pkg::xlen-1:0]       mem_fwd_data;
   logic [cpu_isa_pkg::reg_addr_w-1:0] mem_rd;
   logic                               mem_reg_wr_en;
   logic                               stall;
   logic                               flush_id;
   logic                               flush_ex;
   cpu_pipe_pkg::fwd_sel_e             fwd_a;
   cpu_pipe_pkg::fwd_sel_e             fwd_b;

   cpu_fetch u_fetch (
      .sys_clk       (sys_clk),
      .sys_rst_n     (sys_rst_n),
      .stall         (stall),
      .flush         (flush_id),
      .branch_taken  (branch_taken),
      .branch_target (branch_target),
      .pfm_rd_instr  (pfm_rd_instr),
      .pfm_req_addr  (pfm_req_addr),
      .if_pc         (if_pc),
      .if_instr      (if_instr)
   );

   cpu_decode u_decode (
      .sys_clk   (sys_clk),
      .sys_rst_n (sys_rst_n),
      .stall     (stall),      // Bubble into execute
      .flush     (flush_ex),
      .if_pc     (if_pc),
      .if_instr  (if_instr),
      .wb        (wb),
      .id_rs1    (id_rs1),
      .id_rs2    (id_rs2),
      .id_ex     (id_ex)
   );

   cpu_hazard_unit u_hazard_unit (
      .id_rs1        (id_rs1),
      .id_rs2        (id_rs2),
      .ex_rs1        (ex_rs1),
      .ex_rs2        (ex_rs2),
      .ex_rd         (ex_rd),
      .ex_is_load    (ex_is_load),
      .mem_rd        (mem_rd),
      .mem_reg_wr_en (mem_reg_wr_en),
      .wb            (wb),
      .branch_taken  (branch_taken),
      .stall         (stall),
      .flush_id      (flush_id),
      .flush_ex      (flush_ex),
      .fwd_a         (fwd_a),
      .fwd_b         (fwd_b)
   );

   cpu_execute u_execute (
      .sys_clk       (sys_clk),
      .sys_rst_n     (sys_rst_n),
      .id_ex         (id_ex),
      .fwd_a         (fwd_a),
      .fwd_b         (fwd_b),
      .mem_fwd_data  (mem_fwd_data),
      .wb            (wb),
      .branch_taken  (branch_taken),
      .branch_target (branch_target),
      .ex_rs1        (ex_rs1),
      .ex_rs2        (ex_rs2),
      .ex_rd         (ex_rd),
      .ex_is_load    (ex_is_load),
      .ex_mem        (ex_mem)
   );

   cpu_mem_wb u_mem_wb (
      .sys_clk       (sys_clk),
      .sys_rst_n     (sys_rst_n),
      .ex_mem        (ex_mem),
      .dfm_rd_data   (dfm_rd_data),
      .dfm_req_addr  (dfm_req_addr),
      .dfm_wr_en     (dfm_wr_en),
      .dfm_wr_data   (dfm_wr_data),
      .mem_fwd_data  (mem_fwd_data),
      .mem_rd        (mem_rd),
      .mem_reg_wr_en (mem_reg_wr_en),
      .wb            (wb)
   );

endmodule : cpu_pipeline

`default_nettype wire

/* tests/cpu_pipeline_assert.sv */
// Pipeline port protocol checks
// Bound into the pipeline top level, watches the fetch and data ports
`timescale 1ns/1ps
`default_nettype none

module cpu_pipeline_assert (
   input logic                         sys_clk,
   input logic                         sys_rst_n,
   input logic [cpu_isa_pkg::xlen-1:0] pfm_req_addr,
   input logic                         dfm_wr_en,
   input logic                         branch_taken
);

   int fail_count = 0;   // Failed assertion count

   // No store while in reset or in the first cycle out of it
   no_store_in_reset: assert property (@(posedge sys_clk) !sys_rst_n |-> !dfm_wr_en)
      else begin
         fail_count++;
         $error("Store while reset is held");
      end

   no_store_after_reset: assert property (@(posedge sys_clk) $rose(sys_rst_n) |-> !dfm_wr_en)
      else begin
         fail_count++;
         $error("Store in the first cycle after reset");
      end

   // Word fetches only
   fetch_aligned: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
      pfm_req_addr[1:0] == 2'b00)
      else begin
         fail_count++;
         $error("Fetch address not word aligned");
      end

   // Hold, step by 4, or jump right after a taken BEQ
   fetch_sequence: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
      pfm_req_addr == $past(pfm_req_addr) || pfm_req_addr == $past(pfm_req_addr) + 32'd4
      || $past(branch_taken))
      else begin
         fail_count++;
         $error("Fetch address jumped without a taken branch");
      end

endmodule : cpu_pipeline_assert

bind cpu_pipeline cpu_pipeline_assert u_pipeline_assert (
   .sys_clk      (sys_clk),
   .sys_rst_n    (sys_rst_n),
   .pfm_req_addr (pfm_req_addr),
   .dfm_wr_en    (dfm_wr_en),
   .branch_taken (branch_taken)   // Internal to the top level
);

`default_nettype wire

/* tests/cpu_pipeline_tb.sv */
// Pipeline testbench
// Runs a fixed program from a model instruction memory and checks every store
`timescale 1ns/1ps
`default_nettype none

module cpu_pipeline_tb;

   localparam int max_cycles = 200;   // Program needs about 50 with reset and idle
   localparam int mem_words  = 64;
   localparam logic [31:0] op_x1 = 32'd5;   // Loaded into x1
   localparam logic [31:0] op_x2 = 32'd7;   // Loaded into x2

   logic        sys_clk;
   logic        sys_rst_n;
   logic [31:0] pfm_rd_instr;
   logic [31:0] dfm_rd_data;
   logic [31:0] pfm_req_addr;
   logic [31:0] dfm_req_addr;
   logic        dfm_wr_en;
   logic [31:0] dfm_wr_data;

   logic [31:0] imem [mem_words];
   logic [31:0] dmem [mem_words];
   int          prog_len  = 0;
   int          store_idx = 0;
   int          cycle_cnt = 0;
   string       exp_name [$];
   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];

   cpu_pipeline u_cpu_pipeline (
      .sys_clk      (sys_clk),
      .sys_rst_n    (sys_rst_n),
      .pfm_rd_instr (pfm_rd_instr),
      .dfm_rd_data  (dfm_rd_data),
      .pfm_req_addr (pfm_req_addr),
      .dfm_req_addr (dfm_req_addr),
      .dfm_wr_en    (dfm_wr_en),
      .dfm_wr_data  (dfm_wr_data)
   );

   always #2 sys_clk = ~sys_clk;   // 4 ns period

   // Memory models, combinational read
   assign pfm_rd_instr = imem[pfm_req_addr[7:2]];
   assign dfm_rd_data  = dmem[dfm_req_addr[7:2]];

   always @(posedge sys_clk) begin
      if (dfm_wr_en) dmem[dfm_req_addr[7:2]] <= dfm_wr_data;
   end

   // ==================================================
   // RV32I encoders
   // ==================================================
   function automatic logic [31:0] r_instr(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] i_instr(input logic [6:0] opc, input logic [11:0] imm,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
      return {imm, rs1, f3, rd, opc};   // ADDI and LW
   endfunction

   function automatic logic [31:0] s_instr(input logic [11:0] imm, input logic [4:0] rs2);
      return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};   // SW, base x0
   endfunction

   function automatic logic [31:0] b_instr(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
      return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
   endfunction

   task automatic put_instr(input logic [31:0] word);
      imem[prog_len] = word;
      prog_len++;
   endtask

   task automatic queue_store(input string name, input logic [31:0] addr,
                              input logic [31:0] data);
      exp_name.push_back(name);
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      $display("Something failed");
      $fatal(1);
   endtask

   // ==================================================
   // Store checks, in program order
   // ==================================================
   always @(posedge sys_clk) begin
      if (dfm_wr_en) begin
         if (store_idx >= exp_addr.size()) begin
            $display("Store to 0x%08h beyond the end of the expected store list",
                     dfm_req_addr);
            $display("Something failed");
            $fatal(1);
         end else begin
            store_addr_ok: assert (dfm_req_addr == exp_addr[store_idx])
               else report_mismatch({exp_name[store_idx], " address"},
                                    exp_addr[store_idx], dfm_req_addr);
            store_data_ok: assert (dfm_wr_data == exp_data[store_idx])
               else report_mismatch({exp_name[store_idx], " data"},
                                    exp_data[store_idx], dfm_wr_data);
            store_idx++;
         end
      end
   end

   // Timeout and bound protocol checks
   always @(posedge sys_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= max_cycles) begin
         $display("Timeout after %0d cycles, the program did not finish", max_cycles);
         $display("Something failed");
         $fatal(1);
      end else if (u_cpu_pipeline.u_pipeline_assert.fail_count != 0) begin
         $display("A protocol assertion on the DUT ports failed");
         $display("Something failed");
         $fatal(1);
      end
   end

   initial begin
      int i;
      sys_clk   = 1'b0;
      sys_rst_n = 1'b0;
      for (i = 0; i < mem_words; i++) begin
         imem[i] = 32'h0000_0013;         // NOP
         dmem[i] = 32'hbad0_0000 + i * 4;  // Tag by byte address
      end

      // ==================================================
      // Program
      // ==================================================
      put_instr(i_instr(7'b0010011, op_x1[11:0], 5'd0, 3'b000, 5'd1));   // ADDI x1
      put_instr(i_instr(7'b0010011, op_x2[11:0], 5'd0, 3'b000, 5'd2));   // ADDI x2
      put_instr(r_instr(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));    // ADD x3 = x1 + x2
      put_instr(r_instr(7'h20, 5'd1, 5'd2, 3'b000, 5'd4));    // SUB x4 = x2 - x1
      put_instr(r_instr(7'h00, 5'd2, 5'd1, 3'b111, 5'd8));    // AND
      put_instr(r_instr(7'h00, 5'd2, 5'd1, 3'b110, 5'd9));    // OR
      put_instr(r_instr(7'h00, 5'd2, 5'd1, 3'b100, 5'd10));   // XOR
      put_instr(r_instr(7'h00, 5'd2, 5'd1, 3'b010, 5'd11));   // SLT
      put_instr(s_instr(12'd0, 5'd3));
      put_instr(s_instr(12'd4, 5'd4));
      put_instr(s_instr(12'd8, 5'd8));
      put_instr(s_instr(12'd12, 5'd9));
      put_instr(s_instr(12'd16, 5'd10));   // XOR result
      put_instr(s_instr(12'd20, 5'd11));   // SLT result
      put_instr(i_instr(7'b0000011, 12'd0, 5'd0, 3'b010, 5'd5));   // LW x5, 0
      put_instr(r_instr(7'h00, 5'd5, 5'd5, 3'b000, 5'd6));         // Load-use
      put_instr(s_instr(12'd24, 5'd6));
      put_instr(b_instr(13'd12, 5'd1, 5'd1));                      // Taken
      put_instr(i_instr(7'b0010011, 12'd99, 5'd0, 3'b000, 5'd7));  // Shadow
      put_instr(s_instr(12'd28, 5'd7));                            // Shadow
      put_instr(s_instr(12'd32, 5'd7));
      put_instr(b_instr(13'd8, 5'd2, 5'd1));                       // Not taken
      put_instr(s_instr(12'd36, 5'd2));
      put_instr(b_instr(13'd0, 5'd0, 5'd0));                       // Self-loop

      queue_store("add", 32'd0, op_x1 + op_x2);
      queue_store("sub", 32'd4, op_x2 - op_x1);
      queue_store("and", 32'd8, op_x1 & op_x2);
      queue_store("or", 32'd12, op_x1 | op_x2);
      queue_store("xor", 32'd16, op_x1 ^ op_x2);
      queue_store("slt", 32'd20, ($signed(op_x1) < $signed(op_x2)) ? 32'd1 : 32'd0);
      queue_store("load_use", 32'd24, (op_x1 + op_x2) * 2);
      queue_store("branch_taken", 32'd32, 32'd0);   // x7 never written
      queue_store("branch_not_taken", 32'd36, op_x2);

      repeat (3) @(posedge sys_clk);
      sys_rst_n <= 1'b1;
      @(negedge sys_clk);
      reset_pc_ok: assert (pfm_req_addr == 32'd0)
         else report_mismatch("reset", 32'd0, pfm_req_addr);

      wait (store_idx == exp_addr.size());
      repeat (10) @(posedge sys_clk);   // Idle in the self-loop
      if (u_cpu_pipeline.u_pipeline_assert.fail_count == 0) begin
         $display("Everything OK");
         $finish;
      end else begin
         $display("A protocol assertion on the DUT ports failed");
         $display("Something failed");
         $fatal(1);
      end
   end

endmodule : cpu_pipeline_tb

`default_nettype wire

/* cpu_pipeline.f */
src/cpu_isa_pkg.sv
src/cpu_pipe_pkg.sv
src/cpu_fetch.sv
src/cpu_reg_file.sv
src/cpu_decode.sv
src/cpu_hazard_unit.sv
src/cpu_execute.sv
src/cpu_mem_wb.sv
src/cpu_pipeline.sv
tests/cpu_pipeline_assert.sv
tests/cpu_pipeline_tb.sv

/* Bender.yml */
package:
  name: cpu_pipeline

sources:
  - files:
      - src/cpu_isa_pkg.sv
      - src/cpu_pipe_pkg.sv
      - src/cpu_fetch.sv
      - src/cpu_reg_file.sv
      - src/cpu_decode.sv
      - src/cpu_hazard_unit.sv
      - src/cpu_execute.sv
      - src/cpu_mem_wb.sv
      - src/cpu_pipeline.sv
  - target: test
    files:
      - tests/cpu_pipeline_assert.sv
      - tests/cpu_pipeline_tb.sv
